// File: include/theiaCore_consts.svh
/* Theia core constants */
`ifndef THEIACORE_CONSTS_SVH
`define THEIACORE_CONSTS_SVH

// ----------------------------------------------------------------------------
// Widths
// ----------------------------------------------------------------------------
`define WB_WIDTH          32      // Wishbone data and address
`define LANE_WIDTH        32      // One data component
`define LANE_COUNT        3       // x, y, z
`define DATA_ADDR_WIDTH   7       // 128 data rows
`define ROM_ADDR_WIDTH    8       // 256 instruction words
`define INSTR_WIDTH       32

// Program entry and reserved output rows
`define INITIAL_CODE_ADDR 8'd0
`define OREG_PIXEL_COLOR  7'd1
`define OREG_PIXEL_PITCH  7'd2    // x lane holds the pixel address

// ----------------------------------------------------------------------------
// Opcodes
// ----------------------------------------------------------------------------
`define OP_NOP            4'h0
`define OP_ADD            4'h1
`define OP_SUB            4'h2
`define OP_AND            4'h3
`define OP_MOV            4'h4
`define OP_BZ             4'h5    // Branch if x lane is zero
`define OP_JMP            4'h6
`define OP_RET            4'h7    // Return value from x lane

// Slave tag values
`define TAG_DATA          1'b0
`define TAG_INSTR         1'b1

`endif

// File: logic/theiaIsaPkg.sv
/* Theia microcode instruction word */
`include "theiaCore_consts.svh"

package theiaIsaPkg;

  typedef logic [3:0]                   opcode_t;
  typedef logic [`DATA_ADDR_WIDTH-1:0]  rowAddr_t;
  typedef logic [`ROM_ADDR_WIDTH-1:0]   codeAddr_t;

  // ALU form, dst = src0 op src1
  typedef struct packed {
    opcode_t   opcode;
    rowAddr_t  dst;
    rowAddr_t  src0;
    rowAddr_t  src1;
    logic [`INSTR_WIDTH-4-3*`DATA_ADDR_WIDTH-1:0] pad;
  } aluForm_t;

  // Branch form, also used by RET
  typedef struct packed {
    opcode_t   opcode;                  // Same bits as ALU form
    rowAddr_t  src;                     // Tested row
    codeAddr_t target;
    logic [`INSTR_WIDTH-4-`DATA_ADDR_WIDTH-`ROM_ADDR_WIDTH-1:0] pad;
  } branchForm_t;

  typedef union packed {
    aluForm_t    alu;
    branchForm_t branch;
  } instrWord_t;

  // Opcodes decoded in branch form
  function automatic logic isBranchForm(opcode_t op);
    return (op == `OP_BZ) || (op == `OP_JMP) || (op == `OP_RET);
  endfunction

endpackage

// File: logic/theiaDataPkg.sv
/* Theia data row */
`include "theiaCore_consts.svh"

package theiaDataPkg;

  typedef logic [`LANE_WIDTH-1:0] lane_t;

  // One data row, flat for storage or split in lanes
  typedef union packed {
    logic [`LANE_COUNT*`LANE_WIDTH-1:0] flat;
    lane_t [`LANE_COUNT-1:0]            lane;
  } dataRow_t;

  localparam int LANE_X = 0;            // x sits in the low bits

endpackage

// File: logic/vectorAlu.sv
/* Three-lane vector ALU */
`timescale 1ns/10ps
`include "theiaCore_consts.svh"

module vectorAlu (
  input  theiaIsaPkg::opcode_t   opcode,
  input  theiaDataPkg::dataRow_t srcA,
  input  theiaDataPkg::dataRow_t srcB,
  output theiaDataPkg::dataRow_t result
);

  // Lanes are independent, no carry between them
  always_comb begin
    for (int i = 0; i < `LANE_COUNT; i++) begin
      case (opcode)
        `OP_ADD: result.lane[i] = srcA.lane[i] + srcB.lane[i];
        `OP_SUB: result.lane[i] = srcA.lane[i] - srcB.lane[i];
        `OP_AND: result.lane[i] = srcA.lane[i] & srcB.lane[i];
        `OP_MOV: result.lane[i] = srcA.lane[i];
        default: result.lane[i] = '0;                      // Not written back
      endcase
    end
  end

endmodule

// File: logic/memoryUnit.sv
/* Instruction and data memories */
`timescale 1ns/10ps
`include "theiaCore_consts.svh"

module memoryUnit (
  input  logic                        clock,
  // Instruction memory
  input  logic                        instrWrEn,
  input  logic [`ROM_ADDR_WIDTH-1:0]  instrWrAddr,
  input  logic [`INSTR_WIDTH-1:0]     instrWrData,
  input  logic [`ROM_ADDR_WIDTH-1:0]  instrRdAddr,
  output theiaIsaPkg::instrWord_t     instrRdData,
  // Data memory write
  input  logic                        memWrEn,
  input  logic [`DATA_ADDR_WIDTH-1:0] memWrAddr,
  input  logic [`LANE_COUNT-1:0]      memWrMask,
  input  theiaDataPkg::dataRow_t      memWrData,
  // Data memory reads
  input  logic [`DATA_ADDR_WIDTH-1:0] rdAddr0,
  input  logic [`DATA_ADDR_WIDTH-1:0] rdAddr1,
  output theiaDataPkg::dataRow_t      rdData0,
  output theiaDataPkg::dataRow_t      rdData1
);
  import theiaIsaPkg::*;
  import theiaDataPkg::*;

  localparam int ROW_WIDTH = $bits(dataRow_t);

  instrWord_t           instrMem [0:(1 << `ROM_ADDR_WIDTH)-1];    // 256 words
  logic [ROW_WIDTH-1:0] dataMem  [0:(1 << `DATA_ADDR_WIDTH)-1];   // 128 rows

  // Instruction store, loaded only in config mode
  always_ff @(posedge clock) begin
    if (instrWrEn) begin
      instrMem[instrWrAddr] <= instrWrData;
    end
    instrRdData <= instrMem[instrRdAddr];                         // One cycle latency
  end

  // Data store, old data on a same-cycle read
  always_ff @(posedge clock) begin
    for (int i = 0; i < `LANE_COUNT; i++) begin
      if (memWrEn && memWrMask[i]) begin
        dataMem[memWrAddr][i*`LANE_WIDTH +: `LANE_WIDTH] <= memWrData.lane[i];
      end
    end
    rdData0.flat <= dataMem[rdAddr0];
    rdData1.flat <= dataMem[rdAddr1];
  end

endmodule

// File: logic/executionUnit.sv
/* Microcode execution engine */
`timescale 1ns/10ps
`include "theiaCore_consts.svh"

module executionUnit (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        uCodeStart,
  // Instruction fetch
  output logic [`ROM_ADDR_WIDTH-1:0]  instrRdAddr,
  input  theiaIsaPkg::instrWord_t     instrRdData,
  // Operand reads
  output logic [`DATA_ADDR_WIDTH-1:0] rdAddr0,
  output logic [`DATA_ADDR_WIDTH-1:0] rdAddr1,
  input  theiaDataPkg::dataRow_t      rdData0,
  input  theiaDataPkg::dataRow_t      rdData1,
  // Write back
  output logic [`DATA_ADDR_WIDTH-1:0] exeWrAddr,
  output theiaDataPkg::dataRow_t      exeWrData,
  output logic                        exeWrEn,
  output logic                        uCodeDone,
  output logic                        returnValue
);
  import theiaIsaPkg::*;
  import theiaDataPkg::*;

  typedef enum logic [1:0] {EX_IDLE, EX_FETCH, EX_READ, EX_EXEC} exState_t;

  exState_t  state;
  codeAddr_t ip;
  opcode_t   opcode;
  logic      branchForm;
  logic      isAluOp;
  logic      testZero;
  dataRow_t  aluResult;

  // ----------------------------------------------------------------------------
  // Decode, word stays valid from READ through EXEC since ip holds
  // ----------------------------------------------------------------------------
  assign instrRdAddr = ip;
  assign opcode      = instrRdData.alu.opcode;             // Same field in both forms
  assign branchForm  = isBranchForm(opcode);
  assign isAluOp     = opcode inside {`OP_ADD, `OP_SUB, `OP_AND, `OP_MOV};

  assign rdAddr0  = branchForm ? instrRdData.branch.src : instrRdData.alu.src0;
  assign rdAddr1  = instrRdData.alu.src1;
  assign testZero = (rdData0.lane[LANE_X] == '0);          // BZ and RET test x lane

  vectorAlu u_vectorAlu (
    .opcode (opcode),
    .srcA   (rdData0),
    .srcB   (rdData1),
    .result (aluResult)
  );

  // Write back and return in the execute cycle
  assign exeWrEn     = (state == EX_EXEC) && isAluOp;
  assign exeWrAddr   = instrRdData.alu.dst;
  assign exeWrData   = aluResult;
  assign uCodeDone   = (state == EX_EXEC) && (opcode == `OP_RET);
  assign returnValue = ~testZero;                          // Valid with uCodeDone

  // ----------------------------------------------------------------------------
  // Sequencer, three cycles per instruction
  // ----------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= EX_IDLE;
      ip    <= `INITIAL_CODE_ADDR;
    end else if (uCodeStart) begin
      state <= EX_FETCH;
      ip    <= `INITIAL_CODE_ADDR;
    end else begin
      case (state)
        EX_FETCH: state <= EX_READ;
        EX_READ:  state <= EX_EXEC;
        EX_EXEC: begin
          state <= uCodeDone ? EX_IDLE : EX_FETCH;
          case (opcode)
            `OP_JMP: ip <= instrRdData.branch.target;
            `OP_BZ:  ip <= testZero ? instrRdData.branch.target : ip + 1'b1;
            default: ip <= ip + 1'b1;                      // Unknown codes act as NOP
          endcase
        end
        default:  ;                                        // Wait for start
      endcase
    end
  end

endmodule

// File: logic/controlUnit.sv
/* Main control FSM */
`timescale 1ns/10ps
`include "theiaCore_consts.svh"

module controlUnit (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        configMode,
  input  logic                        uCodeDone,
  input  logic                        returnValue,
  input  logic                        ioDone,
  output logic                        uCodeStart,
  output logic                        pixelStart,
  output logic                        ramOwnerExe,
  // Write sources
  input  logic [`DATA_ADDR_WIDTH-1:0] exeWrAddr,
  input  theiaDataPkg::dataRow_t      exeWrData,
  input  logic                        exeWrEn,
  input  logic [`DATA_ADDR_WIDTH-1:0] ioWrAddr,
  input  theiaDataPkg::dataRow_t      ioWrData,
  input  logic [`LANE_COUNT-1:0]      ioWrMask,
  input  logic                        ioWrEn,
  // To data memory
  output logic [`DATA_ADDR_WIDTH-1:0] memWrAddr,
  output theiaDataPkg::dataRow_t      memWrData,
  output logic [`LANE_COUNT-1:0]      memWrMask,
  output logic                        memWrEn
);
  typedef enum logic [2:0] {CU_IDLE, CU_CONFIG, CU_START, CU_RUNNING, CU_PIXEL} cuState_t;

  cuState_t state;
  logic     configModeQ;
  logic     configFall;

  assign configFall  = configModeQ & ~configMode;
  assign uCodeStart  = (state == CU_START);                    // One cycle, then running
  assign ramOwnerExe = (state == CU_START) || (state == CU_RUNNING);

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= CU_IDLE;
      configModeQ <= 1'b0;
      pixelStart  <= 1'b0;
    end else begin
      configModeQ <= configMode;
      pixelStart  <= 1'b0;
      case (state)
        CU_CONFIG:  if (configFall) state <= CU_START;
        CU_START:   state <= CU_RUNNING;
        CU_RUNNING: begin
          if (uCodeDone && returnValue) begin
            state      <= CU_PIXEL;
            pixelStart <= 1'b1;                                // Pixel write follows
          end else if (uCodeDone) begin
            state <= CU_IDLE;                                  // Nothing to write
          end
        end
        CU_PIXEL:   if (ioDone) state <= CU_IDLE;
        default:    ;
      endcase
      if (configMode && state != CU_CONFIG) begin
        state <= CU_CONFIG;                                    // Host takes over again
      end
    end
  end

  // Write port mux, engine writes whole rows
  assign memWrAddr = ramOwnerExe ? exeWrAddr : ioWrAddr;
  assign memWrData = ramOwnerExe ? exeWrData : ioWrData;
  assign memWrMask = ramOwnerExe ? {`LANE_COUNT{1'b1}} : ioWrMask;
  assign memWrEn   = ramOwnerExe ? exeWrEn : ioWrEn;

endmodule

// File: logic/ioUnit.sv
/* Wishbone slave and pixel master */
`timescale 1ns/10ps
`include "theiaCore_consts.svh"

module ioUnit (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        configMode,
  // Configuration slave
  input  logic [`WB_WIDTH-1:0]        slvAdr,
  input  logic [`WB_WIDTH-1:0]        slvDat,
  input  logic                        slvWe,
  input  logic                        slvStb,
  input  logic                        slvCyc,
  input  logic                        slvTag,
  output logic                        slvAck,
  // Memory writes
  output logic [`DATA_ADDR_WIDTH-1:0] ioWrAddr,
  output theiaDataPkg::dataRow_t      ioWrData,
  output logic [`LANE_COUNT-1:0]      ioWrMask,
  output logic                        ioWrEn,
  output logic                        instrWrEn,
  output logic [`ROM_ADDR_WIDTH-1:0]  instrWrAddr,
  output logic [`INSTR_WIDTH-1:0]     instrWrData,
  // Pixel fetch
  input  logic                        pixelStart,
  output logic [`DATA_ADDR_WIDTH-1:0] pxRdAddr,
  input  theiaDataPkg::dataRow_t      pxRdData,
  // Pixel master
  output logic [`WB_WIDTH-1:0]        mstAdr,
  output logic [`WB_WIDTH-1:0]        mstDat,
  output logic                        mstWe,
  output logic                        mstStb,
  output logic                        mstCyc,
  input  logic                        mstAck,
  output logic                        ioDone
);
  import theiaDataPkg::*;

  localparam logic [`LANE_COUNT-1:0] ONE_LANE = 1;

  typedef enum logic [1:0] {PX_IDLE, PX_PITCH, PX_BUS} pxState_t;

  pxState_t               pxState;
  logic                   slvReq;
  logic [1:0]             slvLane;
  logic [`LANE_WIDTH-1:0] pxColor;

  // ----------------------------------------------------------------------------
  // Slave side
  // ----------------------------------------------------------------------------
  assign slvReq  = slvCyc & slvStb & configMode & ~slvAck;   // Once per strobe
  assign slvLane = slvAdr[1:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      slvAck    <= 1'b0;
      ioWrEn    <= 1'b0;
      instrWrEn <= 1'b0;
    end else begin
      slvAck    <= slvReq;                                    // Reads ack with no effect
      ioWrEn    <= slvReq & slvWe & (slvTag == `TAG_DATA);
      instrWrEn <= slvReq & slvWe & (slvTag == `TAG_INSTR);
    end
  end

  always_ff @(posedge clock) begin
    if (slvReq) begin
      ioWrAddr      <= slvAdr[2 +: `DATA_ADDR_WIDTH];
      ioWrMask      <= ONE_LANE << slvLane;                   // Lane 3 writes nothing
      ioWrData.flat <= {`LANE_COUNT{slvDat}};
      instrWrAddr   <= slvAdr[2 +: `ROM_ADDR_WIDTH];
      instrWrData   <= slvDat;
    end
  end

  // ----------------------------------------------------------------------------
  // Master side, color then pitch over the shared port
  // ----------------------------------------------------------------------------
  assign pxRdAddr = (pxState == PX_IDLE) ? `OREG_PIXEL_COLOR : `OREG_PIXEL_PITCH;
  assign mstStb   = mstCyc;
  assign mstWe    = mstCyc;                                   // Write cycles only
  assign mstAdr   = mstCyc ? pxRdData.lane[LANE_X] : '0;      // Pitch row held on the port
  assign mstDat   = mstCyc ? pxColor : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      pxState <= PX_IDLE;
      mstCyc  <= 1'b0;
      ioDone  <= 1'b0;
    end else begin
      ioDone <= 1'b0;
      case (pxState)
        PX_IDLE:  if (pixelStart) pxState <= PX_PITCH;
        PX_PITCH: begin
          mstCyc  <= 1'b1;                                    // Two cycles after start
          pxState <= PX_BUS;
        end
        PX_BUS: begin
          if (mstAck) begin                                   // Waits as long as needed
            mstCyc  <= 1'b0;
            ioDone  <= 1'b1;
            pxState <= PX_IDLE;
          end
        end
        default:  pxState <= PX_IDLE;
      endcase
    end
  end

  // Color arrives one cycle after start
  always_ff @(posedge clock) begin
    if (pxState == PX_PITCH) begin
      pxColor <= pxRdData.lane[LANE_X];
    end
  end

endmodule

// File: logic/theiaCore.sv
/* Theia shader core top level */
`timescale 1ns/10ps
`include "theiaCore_consts.svh"

module theiaCore (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  configMode,   // Host loads code and data while high
  // Configuration slave
  input  logic [`WB_WIDTH-1:0]  slvAdr,
  input  logic [`WB_WIDTH-1:0]  slvDat,
  input  logic                  slvWe,
  input  logic                  slvStb,
  input  logic                  slvCyc,
  input  logic                  slvTag,
  output logic                  slvAck,
  // Pixel master
  output logic [`WB_WIDTH-1:0]  mstAdr,
  output logic [`WB_WIDTH-1:0]  mstDat,
  output logic                  mstWe,
  output logic                  mstStb,
  output logic                  mstCyc,
  input  logic                  mstAck
);
  import theiaIsaPkg::*;
  import theiaDataPkg::*;

  // Sequencing
  logic uCodeStart, uCodeDone, returnValue;
  logic pixelStart, ioDone, ramOwnerExe;

  // Instruction path
  logic                        instrWrEn;
  logic [`ROM_ADDR_WIDTH-1:0]  instrWrAddr, instrRdAddr;
  logic [`INSTR_WIDTH-1:0]     instrWrData;
  instrWord_t                  instrRdData;

  // Data write port, one per source plus the muxed one
  logic [`DATA_ADDR_WIDTH-1:0] exeWrAddr, ioWrAddr, memWrAddr;
  dataRow_t                    exeWrData, ioWrData, memWrData;
  logic [`LANE_COUNT-1:0]      ioWrMask, memWrMask;
  logic                        exeWrEn, ioWrEn, memWrEn;

  // Read ports
  logic [`DATA_ADDR_WIDTH-1:0] rdAddr0, rdAddr1, exeRdAddr1, pxRdAddr;
  dataRow_t                    rdData0, rdData1;

  // Port 1 goes to the IO master whenever the engine does not own memory
  assign rdAddr1 = ramOwnerExe ? exeRdAddr1 : pxRdAddr;

  controlUnit u_controlUnit (
    .clock, .reset, .configMode, .uCodeDone, .returnValue, .ioDone,
    .uCodeStart, .pixelStart, .ramOwnerExe,
    .exeWrAddr, .exeWrData, .exeWrEn,
    .ioWrAddr, .ioWrData, .ioWrMask, .ioWrEn,
    .memWrAddr, .memWrData, .memWrMask, .memWrEn
  );

  memoryUnit u_memoryUnit (
    .clock, .instrWrEn, .instrWrAddr, .instrWrData, .instrRdAddr, .instrRdData,
    .memWrEn, .memWrAddr, .memWrMask, .memWrData,
    .rdAddr0, .rdAddr1, .rdData0, .rdData1
  );

  executionUnit u_executionUnit (
    .clock, .reset, .uCodeStart, .instrRdAddr, .instrRdData,
    .rdAddr0, .rdAddr1(exeRdAddr1), .rdData0, .rdData1,
    .exeWrAddr, .exeWrData, .exeWrEn, .uCodeDone, .returnValue
  );

  ioUnit u_ioUnit (
    .clock, .reset, .configMode,
    .slvAdr, .slvDat, .slvWe, .slvStb, .slvCyc, .slvTag, .slvAck,
    .ioWrAddr, .ioWrData, .ioWrMask, .ioWrEn, .instrWrEn, .instrWrAddr, .instrWrData,
    .pixelStart, .pxRdAddr, .pxRdData(rdData1),
    .mstAdr, .mstDat, .mstWe, .mstStb, .mstCyc, .mstAck, .ioDone
  );

endmodule

// File: sim/theiaCore_properties.sv
/* Theia core bus protocol checks */
`timescale 1ns/10ps
`include "theiaCore_consts.svh"

module theiaCoreProperties (
  input logic                 clock,
  input logic                 reset,
  input logic                 configMode,
  input logic                 slvStb,
  input logic                 slvCyc,
  input logic                 slvAck,
  input logic [`WB_WIDTH-1:0] mstAdr,
  input logic [`WB_WIDTH-1:0] mstDat,
  input logic                 mstWe,
  input logic                 mstStb,
  input logic                 mstCyc,
  input logic                 mstAck
);

  // --------------------------------------------------------------------------
  // Configuration slave
  // --------------------------------------------------------------------------
  slaveAckFollows: assert property (@(posedge clock) disable iff (reset)
      (slvCyc && slvStb && configMode && !slvAck) |=> slvAck)
    else $error("Slave request not acknowledged on the next cycle");

  slaveAckSingle: assert property (@(posedge clock) disable iff (reset)
      slvAck |=> !slvAck)                                  // One cycle wide
    else $error("Slave ack held longer than one cycle");

  slaveAckCause: assert property (@(posedge clock) disable iff (reset)
      slvAck |-> $past(slvCyc && slvStb && configMode))
    else $error("Slave ack without a request");

  // --------------------------------------------------------------------------
  // Pixel master
  // --------------------------------------------------------------------------
  masterStartTogether: assert property (@(posedge clock) disable iff (reset)
      $rose(mstCyc) |-> (mstStb && mstWe))
    else $error("Master cycle started without strobe and write enable");

  // Back-pressure, everything frozen until ack
  masterHold: assert property (@(posedge clock) disable iff (reset)
      (mstCyc && !mstAck) |=> (mstCyc && mstStb && mstWe && $stable(mstAdr) && $stable(mstDat)))
    else $error("Master signals changed while waiting for ack");

  masterRelease: assert property (@(posedge clock) disable iff (reset)
      (mstCyc && mstAck) |=> (!mstCyc && !mstStb && !mstWe))
    else $error("Master cycle did not end one cycle after ack");

  masterStrobeInCycle: assert property (@(posedge clock) disable iff (reset)
      (mstStb || mstWe) |-> mstCyc)
    else $error("Master strobe or write enable outside a cycle");

endmodule

bind theiaCore theiaCoreProperties u_theiaCoreProperties (
  .clock      (clock),
  .reset      (reset),
  .configMode (configMode),
  .slvStb     (slvStb),
  .slvCyc     (slvCyc),
  .slvAck     (slvAck),
  .mstAdr     (mstAdr),
  .mstDat     (mstDat),
  .mstWe      (mstWe),
  .mstStb     (mstStb),
  .mstCyc     (mstCyc),
  .mstAck     (mstAck)
);

// File: sim/tbTheiaCore.sv
/* Theia core testbench */
`timescale 1ns/10ps
`include "theiaCore_consts.svh"

module tbTheiaCore;
  import theiaIsaPkg::*;
  import theiaDataPkg::*;

  localparam int SCENARIO_COUNT = 4;
  localparam rowAddr_t ROW_A      = 7'd10;
  localparam rowAddr_t ROW_B      = 7'd11;
  localparam rowAddr_t ROW_SUM    = 7'd12;
  localparam rowAddr_t ROW_DIFF   = 7'd13;
  localparam rowAddr_t ROW_MASKED = 7'd14;
  localparam rowAddr_t ROW_ONE    = 7'd21;                 // x lane is 1
  localparam rowAddr_t ROW_ZERO   = 7'd30;                 // x lane is 0
  localparam rowAddr_t ROW_V1     = 7'd31;
  localparam rowAddr_t ROW_V2     = 7'd32;
  localparam rowAddr_t ROW_V3     = 7'd33;

  logic                 clock = 1'b0;
  logic                 reset, configMode;
  logic [`WB_WIDTH-1:0] slvAdr, slvDat, mstAdr, mstDat;
  logic                 slvWe, slvStb, slvCyc, slvTag, slvAck;
  logic                 mstWe, mstStb, mstCyc, mstAck;

  logic [31:0] lcgState = 32'h41b5_aa33;
  logic [31:0] expColor = '0;
  logic [31:0] expPitch = '0;
  logic        writeExpected = 1'b0;
  logic        stimulusStarted = 1'b0;
  logic        mstCycQ;
  codeAddr_t   progAddr;
  int          mstCycCount, expectedWrites = 0;
  int          assertErrors = 0;                            // From concurrent checks
  int          flowErrors = 0;                              // From the stimulus thread

  always #10 clock = ~clock;                                // 20 ns period

  theiaCore u_theiaCore (
    .clock, .reset, .configMode,
    .slvAdr, .slvDat, .slvWe, .slvStb, .slvCyc, .slvTag, .slvAck,
    .mstAdr, .mstDat, .mstWe, .mstStb, .mstCyc, .mstAck
  );

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  idleAfterReset: assert property (@(posedge clock) disable iff (reset)
      !stimulusStarted |-> !(slvAck || mstCyc || mstStb))
    else begin
      assertErrors++;
      $display("%0t slave ack or master cycle active before any stimulus", $time);
    end

  colorValue: assert property (@(posedge clock) disable iff (reset)
      (mstCyc && mstAck) |-> (mstDat == expColor))
    else begin
      assertErrors++;
      $display("ERR %0t mstDat expected %h actual %h", $time, expColor, $sampled(mstDat));
    end

  pitchValue: assert property (@(posedge clock) disable iff (reset)
      (mstCyc && mstAck) |-> (mstAdr == expPitch))
    else begin
      assertErrors++;
      $display("ERR %0t mstAdr expected %h actual %h", $time, expPitch, $sampled(mstAdr));
    end

  noStrayWrite: assert property (@(posedge clock) disable iff (reset)
      $rose(mstCyc) |-> writeExpected)
    else begin
      assertErrors++;
      $display("%0t master write started for a program that returned zero", $time);
    end

  // Master cycles seen on the bus
  always @(posedge clock) begin
    if (reset) begin
      mstCycQ     <= 1'b0;
      mstCycCount <= 0;
    end else begin
      mstCycQ <= mstCyc;
      if (mstCyc && !mstCycQ) mstCycCount <= mstCycCount + 1;
    end
  end

  // --------------------------------------------------------------------------
  // Bus and program tasks
  // --------------------------------------------------------------------------
  task automatic busWrite(input logic tag, input logic [31:0] adr, input logic [31:0] dat);
    int waitCount;
    slvAdr <= adr;
    slvDat <= dat;
    slvTag <= tag;
    slvWe  <= 1'b1;
    slvStb <= 1'b1;
    slvCyc <= 1'b1;
    waitCount = 0;
    do begin
      @(posedge clock);
      waitCount++;
    end while (!slvAck && waitCount < 8);
    assert (slvAck) else begin
      flowErrors++;
      $display("%0t slave write to %h was never acknowledged", $time, adr);
    end
    slvStb <= 1'b0;                                         // Drop after ack
    slvCyc <= 1'b0;
    slvWe  <= 1'b0;
    @(posedge clock);
  endtask

  task automatic writeLane(input rowAddr_t row, input int lane, input logic [31:0] value);
    busWrite(`TAG_DATA, (32'(row) << 2) | 32'(lane), value);
  endtask

  task automatic loadRow(input rowAddr_t row, input dataRow_t value);
    for (int i = 0; i < `LANE_COUNT; i++) begin
      writeLane(row, i, value.lane[i]);
    end
  endtask

  task automatic putAlu(input opcode_t op, input rowAddr_t dst, input rowAddr_t src0,
                        input rowAddr_t src1);
    instrWord_t word;
    word = '0;
    word.alu.opcode = op;
    word.alu.dst    = dst;
    word.alu.src0   = src0;
    word.alu.src1   = src1;
    busWrite(`TAG_INSTR, 32'(progAddr) << 2, word);
    progAddr = progAddr + 8'd1;
  endtask

  task automatic putBranch(input opcode_t op, input rowAddr_t src, input codeAddr_t target);
    instrWord_t word;
    word = '0;
    word.branch.opcode = op;
    word.branch.src    = src;
    word.branch.target = target;
    busWrite(`TAG_INSTR, 32'(progAddr) << 2, word);
    progAddr = progAddr + 8'd1;
  endtask

  task automatic serveMaster();
    int waitCount;
    int ackDelay;
    waitCount = 0;
    while (!mstCyc && waitCount < 20) begin
      @(posedge clock);
      waitCount++;
    end
    assert (mstCyc) else begin
      flowErrors++;
      $display("%0t master write cycle never started", $time);
    end
    ackDelay = int'(nextRandom() % 32'd5);                  // Random back-pressure
    repeat (ackDelay) @(posedge clock);
    mstAck <= 1'b1;
    @(posedge clock);
    mstAck <= 1'b0;
  endtask

  // Leave config mode, wait for RET, then serve or watch the master
  task automatic runProgram(input logic expectWrite);
    int waitCount;
    writeExpected = expectWrite;
    configMode <= 1'b0;
    waitCount = 0;
    do begin
      @(posedge clock);
      waitCount++;
    end while (!u_theiaCore.uCodeDone && waitCount < 300);
    assert (u_theiaCore.uCodeDone) else begin
      flowErrors++;
      $display("%0t program did not reach its return", $time);
    end
    if (expectWrite) begin
      expectedWrites++;
      serveMaster();
    end
    repeat (8) @(posedge clock);                            // Window for stray cycles
    configMode <= 1'b1;
    @(posedge clock);
  endtask

  task automatic loadCommonRows();
    expPitch = nextRandom() & 32'hffff_fffc;
    writeLane(`OREG_PIXEL_PITCH, LANE_X, expPitch);
    writeLane(ROW_ONE, LANE_X, 32'd1);
    writeLane(ROW_ZERO, LANE_X, 32'd0);
  endtask

  // --------------------------------------------------------------------------
  // Scenarios
  // --------------------------------------------------------------------------
  task automatic arithScenario();
    dataRow_t rowA;
    dataRow_t rowB;
    for (int i = 0; i < `LANE_COUNT; i++) begin
      rowA.lane[i] = nextRandom();
      rowB.lane[i] = nextRandom();
    end
    loadCommonRows();
    loadRow(ROW_A, rowA);
    loadRow(ROW_B, rowB);
    progAddr = `INITIAL_CODE_ADDR;
    putAlu(`OP_ADD, ROW_SUM, ROW_A, ROW_B);
    putAlu(`OP_SUB, ROW_DIFF, ROW_A, ROW_B);
    putAlu(`OP_AND, ROW_MASKED, ROW_SUM, ROW_DIFF);
    putAlu(`OP_MOV, `OREG_PIXEL_COLOR, ROW_MASKED, ROW_SUM);  // Copies the first source
    putBranch(`OP_RET, ROW_ONE, 8'd0);
    // Expected x lane with 32-bit wrap
    expColor = (rowA.lane[LANE_X] + rowB.lane[LANE_X]) &
               (rowA.lane[LANE_X] - rowB.lane[LANE_X]);
    runProgram(1'b1);
  endtask

  task automatic branchScenario();
    logic [31:0] v1;
    v1 = nextRandom();
    loadCommonRows();
    writeLane(ROW_V1, LANE_X, v1);
    writeLane(ROW_V2, LANE_X, ~v1);
    writeLane(ROW_V3, LANE_X, v1 ^ 32'h0000_ffff);
    progAddr = `INITIAL_CODE_ADDR;
    putAlu(`OP_MOV, `OREG_PIXEL_COLOR, ROW_V1, ROW_V1);    // 0
    putBranch(`OP_BZ, ROW_ZERO, 8'd3);                      // 1 taken
    putAlu(`OP_MOV, `OREG_PIXEL_COLOR, ROW_V2, ROW_V2);    // 2 skipped
    putBranch(`OP_JMP, ROW_ONE, 8'd5);                      // 3 nonzero row
    putAlu(`OP_MOV, `OREG_PIXEL_COLOR, ROW_V3, ROW_V3);    // 4 skipped
    putBranch(`OP_RET, ROW_ONE, 8'd0);                      // 5
    expColor = v1;
    runProgram(1'b1);
  endtask

  task automatic zeroReturnScenario();
    loadCommonRows();
    progAddr = `INITIAL_CODE_ADDR;
    putAlu(`OP_MOV, `OREG_PIXEL_COLOR, ROW_V2, ROW_V2);
    putBranch(`OP_RET, ROW_ZERO, 8'd0);                     // Returns zero
    runProgram(1'b0);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin : stimulus
    reset      = 1'b1;
    configMode = 1'b0;
    slvAdr     = '0;
    slvDat     = '0;
    slvWe      = 1'b0;
    slvStb     = 1'b0;
    slvCyc     = 1'b0;
    slvTag     = 1'b0;
    mstAck     = 1'b0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    repeat (3) @(posedge clock);                            // Quiet outputs checked here
    stimulusStarted = 1'b1;
    configMode <= 1'b1;
    @(posedge clock);
    arithScenario();
    arithScenario();
    branchScenario();
    zeroReturnScenario();
    assert (mstCycCount == expectedWrites) else begin
      flowErrors++;
      $display("ERR %0t mstCyc rising edges expected %0d actual %0d",
               $time, expectedWrites, mstCycCount);
    end
    $display("Closing count %0d assertion errors, %0d flow errors, %0d of %0d pixel writes",
             assertErrors, flowErrors, mstCycCount, expectedWrites);
    if (assertErrors + flowErrors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Budget of 400 cycles per scenario
  initial begin : watchdog
    repeat (SCENARIO_COUNT * 400) @(posedge clock);
    $display("Watchdog expired after %0d cycles before the run completed", SCENARIO_COUNT * 400);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
logic/theiaIsaPkg.sv
logic/theiaDataPkg.sv
logic/vectorAlu.sv
logic/memoryUnit.sv
logic/executionUnit.sv
logic/controlUnit.sv
logic/ioUnit.sv
logic/theiaCore.sv
sim/theiaCore_properties.sv
sim/tbTheiaCore.sv

// File: Makefile
# Verilator flow for the Theia core testbench
VERILATOR ?= verilator
TOP       ?= tbTheiaCore
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/10ps
VFLAGS    ?= --binary --assert --timing --timescale $(TIMESCALE)
PASS_TEXT ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides, the simulator exit status is not trusted
run: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && ! grep -q "%Error" $(LOG) || \
		(echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
